//--- apu_pkg.sv
// Shared APU cluster definitions
`default_nettype none

package apu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Data path
   ////////////////////////////////////////////////////////////////////////////

   // Operand and result width
   localparam int unsigned DATA_W = 32;

   typedef logic [DATA_W-1:0] data_t;

   ////////////////////////////////////////////////////////////////////////////
   // Unit types and ops
   ////////////////////////////////////////////////////////////////////////////

   // Number of unit types behind the dispatch
   localparam int unsigned NB_UNITS = 2;

   // Unit selector carried with each core request
   typedef enum logic {
      UNIT_MULT = 1'b0,
      UNIT_DIV  = 1'b1
   } apu_unit_e;

   // Multiplier ops
   typedef enum logic {
      MUL   = 1'b0,   // low word of the product
      MULHU = 1'b1    // unsigned high word
   } mult_op_e;

   // Divider ops, both unsigned
   typedef enum logic {
      DIVU = 1'b0,
      REMU = 1'b1
   } div_op_e;

endpackage

`default_nettype wire

//--- apu_unit_if.sv
// Tagged request and result channel
`timescale 1ns/1ps
`default_nettype none

interface apu_unit_if #(
   parameter int unsigned NB_CORES = 4,
   parameter type         op_t     = logic
);

   localparam int unsigned TAG_W = $clog2(NB_CORES);

   // Request direction
   logic               req;
   logic               ack;
   op_t                op;
   apu_pkg::data_t     opa;
   apu_pkg::data_t     opb;
   logic [TAG_W-1:0]   tag;

   // Result direction
   logic               rvalid;
   apu_pkg::data_t     result;
   logic [TAG_W-1:0]   rtag;
   logic               rready;

   // Core side or arbiter toward its unit
   modport requester (
      output req, op, opa, opb, tag, rready,
      input  ack, rvalid, result, rtag
   );

   // Arbiter toward cores or execution unit
   modport unit (
      input  req, op, opa, opb, tag, rready,
      output ack, rvalid, result, rtag
   );

endinterface

`default_nettype wire

//--- apu_dispatch.sv
// Core request dispatch
`timescale 1ns/1ps
`default_nettype none

module apu_dispatch #(
   parameter int unsigned NB_CORES = 4
) (
   input  logic [NB_CORES-1:0]   core_req_i,
   input  logic [NB_CORES-1:0]   core_unit_i,
   input  logic [NB_CORES-1:0]   core_op_i,
   input  apu_pkg::data_t        core_opa_i    [NB_CORES-1:0],
   input  apu_pkg::data_t        core_opb_i    [NB_CORES-1:0],
   input  logic [NB_CORES-1:0]   core_ready_i,
   output logic [NB_CORES-1:0]   core_ack_o,
   output logic [NB_CORES-1:0]   core_valid_o,
   output apu_pkg::data_t        core_result_o [NB_CORES-1:0],
   apu_unit_if.requester         mult_if       [NB_CORES-1:0],
   apu_unit_if.requester         div_if        [NB_CORES-1:0]
);

   localparam int unsigned TAG_W = $clog2(NB_CORES);

   for (genvar i = 0; i < NB_CORES; i++) begin : gen_core
      logic                          sel_div;
      logic [apu_pkg::NB_UNITS-1:0]  unit_ack;
      logic [apu_pkg::NB_UNITS-1:0]  unit_valid;
      apu_pkg::data_t                unit_result [apu_pkg::NB_UNITS];
      apu_pkg::data_t                merged;

      assign sel_div = (core_unit_i[i] == apu_pkg::UNIT_DIV);

      // Multiplier row, request raised only when selected
      assign mult_if[i].req    = core_req_i[i] & ~sel_div;
      assign mult_if[i].op     = apu_pkg::mult_op_e'(core_op_i[i]);
      assign mult_if[i].opa    = core_opa_i[i];
      assign mult_if[i].opb    = core_opb_i[i];
      assign mult_if[i].tag    = TAG_W'(i);
      assign mult_if[i].rready = core_ready_i[i];

      // Divider row
      assign div_if[i].req    = core_req_i[i] & sel_div;
      assign div_if[i].op     = apu_pkg::div_op_e'(core_op_i[i]);
      assign div_if[i].opa    = core_opa_i[i];
      assign div_if[i].opb    = core_opb_i[i];
      assign div_if[i].tag    = TAG_W'(i);
      assign div_if[i].rready = core_ready_i[i];

      assign unit_ack[apu_pkg::UNIT_MULT]    = mult_if[i].ack;
      assign unit_ack[apu_pkg::UNIT_DIV]     = div_if[i].ack;
      assign unit_valid[apu_pkg::UNIT_MULT]  = mult_if[i].rvalid;
      assign unit_valid[apu_pkg::UNIT_DIV]   = div_if[i].rvalid;
      assign unit_result[apu_pkg::UNIT_MULT] = mult_if[i].result;
      assign unit_result[apu_pkg::UNIT_DIV]  = div_if[i].result;

      // One request outstanding per core, so at most one unit is valid
      always_comb begin
         merged = '0;
         for (int u = 0; u < apu_pkg::NB_UNITS; u++) begin
            if (unit_valid[u]) begin
               merged = unit_result[u];
            end
         end
      end

      assign core_ack_o[i]    = |unit_ack;
      assign core_valid_o[i]  = |unit_valid;
      assign core_result_o[i] = merged;
   end

endmodule

`default_nettype wire

//--- apu_arbiter.sv
// Round-robin unit arbiter
`timescale 1ns/1ps
`default_nettype none

module apu_arbiter #(
   parameter int unsigned NB_CORES = 4,
   parameter type         op_t     = logic
) (
   input  logic           clk_i,
   input  logic           rst_n_i,
   apu_unit_if.unit       cores [NB_CORES-1:0],
   apu_unit_if.requester  exe
);

   localparam int unsigned TAG_W = $clog2(NB_CORES);

   logic [NB_CORES-1:0]  req_vec;
   logic [NB_CORES-1:0]  rready_vec;
   op_t                  op_vec  [NB_CORES];
   apu_pkg::data_t       opa_vec [NB_CORES];
   apu_pkg::data_t       opb_vec [NB_CORES];
   logic [TAG_W-1:0]     tag_vec [NB_CORES];

   logic                 gnt_valid;
   logic [TAG_W-1:0]     gnt_idx;
   logic [TAG_W-1:0]     rr_q;

   ////////////////////////////////////////////////////////////////////////////
   // Core side
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < NB_CORES; i++) begin : gen_core
      assign req_vec[i]    = cores[i].req;
      assign rready_vec[i] = cores[i].rready;
      assign op_vec[i]     = cores[i].op;
      assign opa_vec[i]    = cores[i].opa;
      assign opb_vec[i]    = cores[i].opb;
      assign tag_vec[i]    = cores[i].tag;

      // Ack goes to the granted core only
      assign cores[i].ack    = exe.ack & (gnt_idx == TAG_W'(i));

      // Result steered back by tag
      assign cores[i].rvalid = exe.rvalid & (exe.rtag == TAG_W'(i));
      assign cores[i].result = exe.result;
      assign cores[i].rtag   = exe.rtag;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Grant selection
   ////////////////////////////////////////////////////////////////////////////

   // First requester at or after the pointer
   always_comb begin : rr_pick
      int unsigned cand;
      gnt_valid = 1'b0;
      gnt_idx   = '0;
      for (int unsigned k = 0; k < NB_CORES; k++) begin
         cand = (rr_q + k) % NB_CORES;
         if (!gnt_valid && req_vec[cand]) begin
            gnt_valid = 1'b1;
            gnt_idx   = TAG_W'(cand);
         end
      end
   end

   assign exe.req    = gnt_valid;
   assign exe.op     = op_vec[gnt_idx];
   assign exe.opa    = opa_vec[gnt_idx];
   assign exe.opb    = opb_vec[gnt_idx];
   assign exe.tag    = tag_vec[gnt_idx];
   assign exe.rready = rready_vec[exe.rtag];

   // Pointer moves past the core that just transferred
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rr_q <= '0;
      end else if (exe.req && exe.ack) begin
         rr_q <= (gnt_idx == TAG_W'(NB_CORES - 1)) ? '0 : gnt_idx + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- int_mult_unit.sv
// Pipelined integer multiplier
`timescale 1ns/1ps
`default_nettype none

module int_mult_unit #(
   parameter int unsigned NB_CORES    = 4,
   parameter int unsigned MULT_STAGES = 3
) (
   input  logic      clk_i,
   input  logic      rst_n_i,
   apu_unit_if.unit  exe
);

   localparam int unsigned TAG_W  = $clog2(NB_CORES);
   localparam int unsigned PROD_W = 2 * apu_pkg::DATA_W;
   localparam int unsigned LAST   = MULT_STAGES - 1;

   logic [PROD_W-1:0]       product;
   apu_pkg::data_t          word;
   logic                    stall;

   logic [MULT_STAGES-1:0]  valid_q;
   apu_pkg::data_t          data_q [MULT_STAGES];
   logic [TAG_W-1:0]        tag_q  [MULT_STAGES];

   // Unsigned 64-bit product, word picked before the pipe
   assign product = PROD_W'(exe.opa) * PROD_W'(exe.opb);
   assign word    = (exe.op == apu_pkg::MULHU) ? product[PROD_W-1:apu_pkg::DATA_W]
                                               : product[apu_pkg::DATA_W-1:0];

   // Whole chain freezes while the output waits
   assign stall   = valid_q[LAST] & ~exe.rready;
   assign exe.ack = exe.req & ~stall;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= '0;
      end else if (!stall) begin
         valid_q[0] <= exe.ack;
         for (int s = 1; s < MULT_STAGES; s++) begin
            valid_q[s] <= valid_q[s-1];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!stall) begin
         data_q[0] <= word;
         tag_q[0]  <= exe.tag;
         for (int s = 1; s < MULT_STAGES; s++) begin
            data_q[s] <= data_q[s-1];
            tag_q[s]  <= tag_q[s-1];
         end
      end
   end

   assign exe.rvalid = valid_q[LAST];
   assign exe.result = data_q[LAST];
   assign exe.rtag   = tag_q[LAST];

endmodule

`default_nettype wire

//--- int_div_datapath.sv
// Restoring divider datapath
`timescale 1ns/1ps
`default_nettype none

module int_div_datapath (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              start_i,
   input  logic              step_i,
   input  apu_pkg::div_op_e  op_i,
   input  apu_pkg::data_t    dividend_i,
   input  apu_pkg::data_t    divisor_i,
   output apu_pkg::data_t    result_o
);

   localparam int unsigned W = apu_pkg::DATA_W;

   apu_pkg::data_t  rem_q;
   apu_pkg::data_t  quo_q;
   apu_pkg::data_t  dvs_q;
   logic [W:0]      trial;
   logic [W:0]      diff;
   logic            fits;

   // Next dividend bit shifted into the partial remainder
   assign trial = {rem_q, quo_q[W-1]};
   assign diff  = trial - {1'b0, dvs_q};
   assign fits  = (trial >= {1'b0, dvs_q});

   ////////////////////////////////////////////////////////////////////////////
   // Shift-subtract iteration
   ////////////////////////////////////////////////////////////////////////////

   // Quotient register doubles as dividend shifter.
   // A zero divisor always fits, so the quotient fills with ones
   // and the remainder collects the dividend
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rem_q <= '0;
         quo_q <= '0;
         dvs_q <= '0;
      end else if (start_i) begin
         rem_q <= '0;
         quo_q <= dividend_i;
         dvs_q <= divisor_i;
      end else if (step_i) begin
         if (fits) begin
            rem_q <= diff[W-1:0];
            quo_q <= {quo_q[W-2:0], 1'b1};
         end else begin
            rem_q <= trial[W-1:0];
            quo_q <= {quo_q[W-2:0], 1'b0};
         end
      end
   end

   // Result select
   assign result_o = (op_i == apu_pkg::REMU) ? rem_q : quo_q;

endmodule

`default_nettype wire

//--- int_div_ctrl.sv
// Integer divider control
`timescale 1ns/1ps
`default_nettype none

module int_div_ctrl #(
   parameter int unsigned NB_CORES = 4
) (
   input  logic      clk_i,
   input  logic      rst_n_i,
   apu_unit_if.unit  exe,
   output logic      start_o,
   output logic      step_o
);

   localparam int unsigned TAG_W = $clog2(NB_CORES);
   localparam int unsigned CNT_W = $clog2(apu_pkg::DATA_W);

   typedef enum logic [1:0] {
      IDLE,
      BUSY,
      DONE
   } state_e;

   state_e              state_q;
   state_e              state_d;
   logic [CNT_W-1:0]    cnt_q;
   logic [TAG_W-1:0]    tag_q;
   apu_pkg::div_op_e    op_q;
   logic                last_step;

   // Accept a new operation only when idle
   assign exe.ack   = exe.req & (state_q == IDLE);
   assign start_o   = exe.ack;
   assign step_o    = (state_q == BUSY);
   assign last_step = step_o & (cnt_q == CNT_W'(apu_pkg::DATA_W - 1));

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (exe.ack) begin
               state_d = BUSY;
            end
         end
         BUSY: begin
            if (last_step) begin
               state_d = DONE;
            end
         end
         DONE: begin
            if (exe.rready) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         if (start_o) begin
            cnt_q <= '0;
         end else if (step_o) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // Tag and op held for the result
   always_ff @(posedge clk_i) begin
      if (start_o) begin
         tag_q <= exe.tag;
         op_q  <= exe.op;
      end
   end

   int_div_datapath i_int_div_datapath (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .start_i    (start_o),
      .step_i     (step_o),
      .op_i       (op_q),
      .dividend_i (exe.opa),
      .divisor_i  (exe.opb),
      .result_o   (exe.result)
   );

   assign exe.rvalid = (state_q == DONE);
   assign exe.rtag   = tag_q;

endmodule

`default_nettype wire

//--- apu_cluster.sv
// Shared APU cluster top
`timescale 1ns/1ps
`default_nettype none

module apu_cluster #(
   parameter int unsigned NB_CORES    = 4,
   parameter int unsigned MULT_STAGES = 3
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic [NB_CORES-1:0]   core_req_i,
   input  logic [NB_CORES-1:0]   core_unit_i,
   input  logic [NB_CORES-1:0]   core_op_i,
   input  apu_pkg::data_t        core_opa_i    [NB_CORES-1:0],
   input  apu_pkg::data_t        core_opb_i    [NB_CORES-1:0],
   output logic [NB_CORES-1:0]   core_ack_o,
   output logic [NB_CORES-1:0]   core_valid_o,
   output apu_pkg::data_t        core_result_o [NB_CORES-1:0],
   input  logic [NB_CORES-1:0]   core_ready_i
);

   ////////////////////////////////////////////////////////////////////////////
   // Channels
   ////////////////////////////////////////////////////////////////////////////

   // Per-core rows, one per unit type
   apu_unit_if #(.NB_CORES(NB_CORES), .op_t(apu_pkg::mult_op_e)) mult_core_ifs [NB_CORES-1:0] ();
   apu_unit_if #(.NB_CORES(NB_CORES), .op_t(apu_pkg::div_op_e))  div_core_ifs  [NB_CORES-1:0] ();

   // Arbiter to unit
   apu_unit_if #(.NB_CORES(NB_CORES), .op_t(apu_pkg::mult_op_e)) mult_exe_if ();
   apu_unit_if #(.NB_CORES(NB_CORES), .op_t(apu_pkg::div_op_e))  div_exe_if  ();

   apu_dispatch #(
      .NB_CORES (NB_CORES)
   ) i_apu_dispatch (
      .core_req_i    (core_req_i),
      .core_unit_i   (core_unit_i),
      .core_op_i     (core_op_i),
      .core_opa_i    (core_opa_i),
      .core_opb_i    (core_opb_i),
      .core_ready_i  (core_ready_i),
      .core_ack_o    (core_ack_o),
      .core_valid_o  (core_valid_o),
      .core_result_o (core_result_o),
      .mult_if       (mult_core_ifs),
      .div_if        (div_core_ifs)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Integer multiplier
   ////////////////////////////////////////////////////////////////////////////

   apu_arbiter #(
      .NB_CORES (NB_CORES),
      .op_t     (apu_pkg::mult_op_e)
   ) i_mult_arbiter (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .cores   (mult_core_ifs),
      .exe     (mult_exe_if)
   );

   int_mult_unit #(
      .NB_CORES    (NB_CORES),
      .MULT_STAGES (MULT_STAGES)
   ) i_int_mult_unit (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .exe     (mult_exe_if)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Integer divider
   ////////////////////////////////////////////////////////////////////////////

   apu_arbiter #(
      .NB_CORES (NB_CORES),
      .op_t     (apu_pkg::div_op_e)
   ) i_div_arbiter (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .cores   (div_core_ifs),
      .exe     (div_exe_if)
   );

   // Start and step strobes only feed the datapath inside
   int_div_ctrl #(
      .NB_CORES (NB_CORES)
   ) i_int_div_ctrl (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .exe     (div_exe_if),
      .start_o (),
      .step_o  ()
   );

endmodule

`default_nettype wire

//--- tb_apu_cluster.sv
// Shared APU cluster testbench
`timescale 1ns/1ps
`default_nettype none

module tb_apu_cluster;

   localparam int unsigned NB_CORES    = 4;
   localparam int unsigned MULT_STAGES = 3;
   localparam int unsigned TIMEOUT     = 400;
   localparam int unsigned W           = apu_pkg::DATA_W;

   logic                  clk_i;
   logic                  rst_n_i;
   logic [NB_CORES-1:0]   core_req_i;
   logic [NB_CORES-1:0]   core_unit_i;
   logic [NB_CORES-1:0]   core_op_i;
   apu_pkg::data_t        core_opa_i    [NB_CORES-1:0];
   apu_pkg::data_t        core_opb_i    [NB_CORES-1:0];
   logic [NB_CORES-1:0]   core_ack_o;
   logic [NB_CORES-1:0]   core_valid_o;
   apu_pkg::data_t        core_result_o [NB_CORES-1:0];
   logic [NB_CORES-1:0]   core_ready_i;

   integer          seed;
   int              errors;
   int              timeouts;
   string           test_name;
   logic            bp_done;
   apu_pkg::data_t  exp_q       [NB_CORES][$];
   int              grants_seen [NB_CORES][NB_CORES];

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   apu_cluster #(
      .NB_CORES    (NB_CORES),
      .MULT_STAGES (MULT_STAGES)
   ) i_apu_cluster (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .core_req_i    (core_req_i),
      .core_unit_i   (core_unit_i),
      .core_op_i     (core_op_i),
      .core_opa_i    (core_opa_i),
      .core_opb_i    (core_opb_i),
      .core_ack_o    (core_ack_o),
      .core_valid_o  (core_valid_o),
      .core_result_o (core_result_o),
      .core_ready_i  (core_ready_i)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Reference model and stimulus
   ////////////////////////////////////////////////////////////////////////////

   function automatic apu_pkg::data_t expect_result(input logic unit, input logic op,
                                                    input apu_pkg::data_t a,
                                                    input apu_pkg::data_t b);
      logic [2*W-1:0] prod;
      prod = {{W{1'b0}}, a} * {{W{1'b0}}, b};
      if (unit == apu_pkg::UNIT_MULT) begin
         return (op == apu_pkg::MULHU) ? prod[2*W-1:W] : prod[W-1:0];
      end
      // Zero divisor gives all ones and the dividend back
      if (b == '0) begin
         return (op == apu_pkg::DIVU) ? {W{1'b1}} : a;
      end
      return (op == apu_pkg::DIVU) ? a / b : a % b;
   endfunction

   task automatic report_timeout(input int c, input string what);
      timeouts++;
      $display("timeout in %s: core %0d never got its %s", test_name, c, what);
   endtask

   task automatic check_idle();
      assert (core_ack_o == '0) else begin
         errors++;
         $display("error %s: ack expected 0 actual %b", test_name, core_ack_o);
      end
      assert (core_valid_o == '0) else begin
         errors++;
         $display("error %s: valid expected 0 actual %b", test_name, core_valid_o);
      end
   endtask

   // One request, then wait until its result has been taken
   task automatic issue_request(input int c, input logic unit, input logic op,
                                input apu_pkg::data_t a, input apu_pkg::data_t b);
      int   t;
      logic acked;
      core_unit_i[c] = unit;
      core_op_i[c]   = op;
      core_opa_i[c]  = a;
      core_opb_i[c]  = b;
      core_req_i[c]  = 1'b1;
      t = 0;
      @(negedge clk_i);
      while (!core_ack_o[c] && t < TIMEOUT) begin
         t++;
         @(negedge clk_i);
      end
      acked = core_ack_o[c];
      if (acked) begin
         exp_q[c].push_back(expect_result(unit, op, a, b));
      end else begin
         report_timeout(c, "ack");
      end
      @(posedge clk_i);
      #1;
      core_req_i[c] = 1'b0;
      if (acked) begin
         t = 0;
         while (exp_q[c].size() != 0 && t < TIMEOUT) begin
            t++;
            @(posedge clk_i);
         end
         if (exp_q[c].size() != 0) begin
            report_timeout(c, "result");
            exp_q[c].delete();
         end
         #1;
      end
   endtask

   // Mode 0 multiplies, 1 divides, anything else mixes both
   task automatic run_core(input int c, input int mode, input int count);
      apu_pkg::data_t a;
      apu_pkg::data_t b;
      logic           unit;
      int             rnd;
      for (int k = 0; k < count; k++) begin
         a   = $random(seed);
         b   = $random(seed);
         rnd = $random(seed);
         case (mode)
            0:       unit = apu_pkg::UNIT_MULT;
            1:       unit = apu_pkg::UNIT_DIV;
            default: unit = rnd[1];
         endcase
         // Small divisors give long quotients
         if (unit == apu_pkg::UNIT_DIV && rnd[2]) begin
            b = b >> 24;
         end
         issue_request(c, unit, rnd[0], a, b);
      end
   endtask

   task automatic drive_ready();
      int rnd;
      int n;
      n = 0;
      core_ready_i = '0;
      while (!bp_done && n < 20 * TIMEOUT) begin
         @(posedge clk_i);
         #1;
         rnd = $random(seed);
         if (n >= 12) begin
            core_ready_i = rnd[NB_CORES-1:0];
         end
         n++;
      end
      core_ready_i = '1;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Checkers
   ////////////////////////////////////////////////////////////////////////////

   // Outputs are settled at the falling edge
   always @(negedge clk_i) begin : check_results
      apu_pkg::data_t expected;
      if (rst_n_i) begin
         for (int c = 0; c < NB_CORES; c++) begin
            if (core_valid_o[c]) begin
               assert (exp_q[c].size() != 0) else begin
                  errors++;
                  $display("core %0d got a result it never asked for in %s", c, test_name);
               end
               if (core_ready_i[c] && exp_q[c].size() != 0) begin
                  expected = exp_q[c].pop_front();
                  assert (core_result_o[c] == expected) else begin
                     errors++;
                     $display("error %s: core %0d expected %h actual %h",
                              test_name, c, expected, core_result_o[c]);
                  end
               end
            end
         end
      end
   end

   // A waiting core sees each other core granted at most once
   always @(negedge clk_i) begin : check_fairness
      if (rst_n_i) begin
         for (int c = 0; c < NB_CORES; c++) begin
            for (int j = 0; j < NB_CORES; j++) begin
               if (!core_req_i[c] || core_ack_o[c]) begin
                  grants_seen[c][j] = 0;
               end else if (j != c && core_ack_o[j] && core_unit_i[j] == core_unit_i[c]) begin
                  grants_seen[c][j]++;
                  assert (grants_seen[c][j] < 2) else begin
                     errors++;
                     $display("error %s: core %0d acked while %0d waited, expected 1 actual %0d",
                              test_name, j, c, grants_seen[c][j]);
                  end
               end
            end
         end
      end
   end

   for (genvar g = 0; g < NB_CORES; g++) begin : gen_props
      apu_pkg::data_t held;

      always @(posedge clk_i) begin
         held <= core_result_o[g];
      end

      assert property (@(posedge clk_i) disable iff (!rst_n_i)
         (core_valid_o[g] && !core_ready_i[g]) |=>
            (core_valid_o[g] && core_result_o[g] == held))
      else begin
         errors++;
         $display("error %s: core %0d result not held, expected %h actual %h",
                  test_name, g, $sampled(held), $sampled(core_result_o[g]));
      end

      assert property (@(posedge clk_i) disable iff (!rst_n_i)
         core_ack_o[g] |-> core_req_i[g])
      else begin
         errors++;
         $display("core %0d was acknowledged without a request", g);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      seed         = 1;
      errors       = 0;
      timeouts     = 0;
      bp_done      = 1'b0;
      test_name    = "reset";
      rst_n_i      = 1'b0;
      core_req_i   = '0;
      core_unit_i  = '0;
      core_op_i    = '0;
      core_ready_i = '1;
      for (int c = 0; c < NB_CORES; c++) begin
         core_opa_i[c] = '0;
         core_opb_i[c] = '0;
      end

      repeat (5) begin
         @(negedge clk_i);
         check_idle();
      end
      @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      repeat (2) begin
         @(negedge clk_i);
         check_idle();
      end
      @(posedge clk_i);
      #1;

      // All cores on the multiplier at once also exercises fairness
      test_name = "multiply";
      fork
         run_core(0, 0, 8);
         run_core(1, 0, 8);
         run_core(2, 0, 8);
         run_core(3, 0, 8);
      join

      test_name = "divide";
      fork
         run_core(0, 1, 3);
         run_core(1, 1, 3);
         run_core(2, 1, 3);
         run_core(3, 1, 3);
      join

      test_name = "divide by zero";
      issue_request(1, apu_pkg::UNIT_DIV, apu_pkg::DIVU, 32'h1234_5678, '0);
      issue_request(2, apu_pkg::UNIT_DIV, apu_pkg::REMU, 32'h8765_4321, '0);

      test_name = "routing";
      fork
         run_core(0, 2, 6);
         run_core(1, 2, 6);
         run_core(2, 2, 6);
         run_core(3, 2, 6);
      join

      test_name = "back-pressure";
      fork
         begin
            fork
               run_core(0, 2, 4);
               run_core(1, 2, 4);
               run_core(2, 2, 4);
               run_core(3, 2, 4);
            join
            bp_done = 1'b1;
         end
         drive_ready();
      join

      repeat (4) @(posedge clk_i);
      $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
apu_pkg.sv
apu_unit_if.sv
apu_dispatch.sv
apu_arbiter.sv
int_mult_unit.sv
int_div_datapath.sv
int_div_ctrl.sv
apu_cluster.sv
tb_apu_cluster.sv

//--- Bender.yml
package:
  name: apu_cluster

sources:
  - files:
      - apu_pkg.sv
      - apu_unit_if.sv
      - apu_dispatch.sv
      - apu_arbiter.sv
      - int_mult_unit.sv
      - int_div_datapath.sv
      - int_div_ctrl.sv
      - apu_cluster.sv
  - target: test
    files:
      - tb_apu_cluster.sv
